/* fifo_pkg.sv */
// Byte FIFO shared definitions
// Widths, depth and types used by both clock domains of the FIFO
`default_nettype none

package fifo_pkg;

    // -------------------------------------------------------------------------
    // Sizes
    // -------------------------------------------------------------------------

    // Number of byte entries in the register file
    localparam int fifo_depth  = 64;
    localparam int addr_width  = 6;
    // One extra wrap bit tells a full FIFO apart from an empty one
    localparam int ptr_width   = addr_width + 1;
    localparam int data_width  = 8;
    // Flop count for every reset and pointer synchronizer
    localparam int sync_stages = 2;

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------

    typedef logic [addr_width-1:0] rf_addr_t;
    // Holds either a binary or a Gray coded pointer
    typedef logic [ptr_width-1:0]  ptr_t;
    typedef logic [data_width-1:0] byte_t;
    // Entry count from 0 up to fifo_depth
    typedef logic [ptr_width-1:0]  level_t;

    // Register select on Wishbone address bit 0
    typedef enum logic {
        reg_data   = 1'b0,
        reg_status = 1'b1
    } wb_reg_e;

    // Pop port machine
    typedef enum logic [1:0] {
        idle  = 2'd0,
        fetch = 2'd1,
        ack   = 2'd2
    } pop_state_e;

endpackage

`default_nettype wire

/* reset_sync.sv */
// Reset synchronizer
// Asserts asynchronously with arst_n and releases on the local clock
`timescale 1ns/10ps
`default_nettype none

module reset_sync (
     input  wire   clk
    ,input  wire   arst_n
    ,output logic  rst_n
);

    // Shift register that fills with ones after arst_n goes high
    logic [fifo_pkg::sync_stages-1:0] sync_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Every stage clears at once, so the domain enters reset immediately
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[fifo_pkg::sync_stages-2:0], 1'b1};
        end
    end

    // The last stage gives a release aligned to clk
    assign rst_n = sync_q[fifo_pkg::sync_stages-1];

endmodule

`default_nettype wire

/* gray_ptr_sync.sv */
// Gray pointer synchronizer
// Brings a Gray coded FIFO pointer into the local clock domain through a
// chain of flops and turns it back into a binary pointer
`timescale 1ns/10ps
`default_nettype none

module gray_ptr_sync (
     input  wire                  clk
    ,input  wire                  rst_n
    ,input  wire fifo_pkg::ptr_t  gray_in
    ,output fifo_pkg::ptr_t       bin_out
);

    // Synchronizer chain, stage 0 samples the other domain
    fifo_pkg::ptr_t sync_q [fifo_pkg::sync_stages];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fifo_pkg::sync_stages; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            // Only one bit of a Gray pointer moves per step, so a sample
            // caught mid-change lands on either the old or the new value
            sync_q[0] <= gray_in;
            for (int i = 1; i < fifo_pkg::sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Gray to binary, each binary bit is the XOR of all Gray bits at and above it
    always_comb begin
        for (int i = 0; i < fifo_pkg::ptr_width; i++) begin
            bin_out[i] = ^(sync_q[fifo_pkg::sync_stages-1] >> i);
        end
    end

endmodule

`default_nettype wire

/* rf_2p_64x8.sv */
// Two-port 64x8 register file
// Write port on wclk, read port on rclk with a registered data output
// Behavioral model of a two-port memory macro
`timescale 1ns/10ps
`default_nettype none

module rf_2p_64x8 (
     input  wire                      wclk
    ,input  wire                      we
    ,input  wire fifo_pkg::rf_addr_t  waddr
    ,input  wire fifo_pkg::byte_t     wdata

    ,input  wire                      rclk
    ,input  wire                      re
    ,input  wire fifo_pkg::rf_addr_t  raddr

    ,output fifo_pkg::byte_t          rdata
);

    // --------------------------------------------------------------------------
    // Storage array
    // --------------------------------------------------------------------------

    fifo_pkg::byte_t mem [fifo_pkg::fifo_depth];

    // Write port, one row per wclk edge while we is high
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // --------------------------------------------------------------------------
    // Read port
    // --------------------------------------------------------------------------

    // The data register loads only on re and keeps its byte otherwise
    // The FIFO pointers keep a row from being read while it is being written
    always_ff @(posedge rclk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* wb_push_port.sv */
// FIFO push port
// Wishbone classic slave on wclk that writes bytes into the register file,
// owns the write pointer and reports full and level on its status register
`timescale 1ns/10ps
`default_nettype none

module wb_push_port (
     input  wire                      wclk
    ,input  wire                      rst_n

    ,input  wire                      push_cyc
    ,input  wire                      push_stb
    ,input  wire                      push_we
    ,input  wire                      push_adr
    ,input  wire fifo_pkg::byte_t     push_dat_i
    ,output fifo_pkg::byte_t          push_dat_o
    ,output logic                     push_ack

    ,output fifo_pkg::ptr_t           wptr_gray
    ,input  wire fifo_pkg::ptr_t      rptr_bin

    ,output logic                     rf_we
    ,output fifo_pkg::rf_addr_t       rf_waddr
    ,output fifo_pkg::byte_t          rf_wdata
);

    fifo_pkg::ptr_t    wptr_bin;
    fifo_pkg::ptr_t    wptr_bin_nxt;
    fifo_pkg::level_t  level;
    fifo_pkg::wb_reg_e sel;
    logic              full;
    logic              req;
    logic              is_push;
    logic              ack_nxt;

    // --------------------------------------------------------------------------
    // Level and request decode
    // --------------------------------------------------------------------------

    // The read pointer lags behind, so the level may read high but never low
    assign level = wptr_bin - rptr_bin;
    assign full  = (level == fifo_pkg::level_t'(fifo_pkg::fifo_depth));

    // A new request is one that has not been acked yet
    assign req     = push_cyc & push_stb & ~push_ack;
    assign sel     = fifo_pkg::wb_reg_e'(push_adr);
    assign is_push = req & push_we & (sel == fifo_pkg::reg_data);

    // A push into a full FIFO holds ack low until space shows up
    assign ack_nxt = req & ~(is_push & full);

    // Register file write happens on the same edge that raises ack
    assign rf_we        = is_push & ~full;
    assign rf_waddr     = wptr_bin[fifo_pkg::addr_width-1:0];
    assign rf_wdata     = push_dat_i;
    assign wptr_bin_nxt = wptr_bin + 1'b1;

    // --------------------------------------------------------------------------
    // Control state
    // --------------------------------------------------------------------------

    always_ff @(posedge wclk or negedge rst_n) begin
        if (!rst_n) begin
            push_ack  <= 1'b0;
            wptr_bin  <= '0;
            wptr_gray <= '0;
        end else begin
            push_ack <= ack_nxt;
            if (rf_we) begin
                wptr_bin  <= wptr_bin_nxt;
                // Registered Gray copy for the read domain
                wptr_gray <= wptr_bin_nxt ^ (wptr_bin_nxt >> 1);
            end
        end
    end

    // Read data, status byte or zero for the data register
    always_ff @(posedge wclk) begin
        if (req) begin
            if (sel == fifo_pkg::reg_status) begin
                push_dat_o <= {full, level};
            end else begin
                push_dat_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* wb_pop_port.sv */
// FIFO pop port
// Wishbone classic slave on rclk that fetches bytes from the register file,
// owns the read pointer and reports empty and level on its status register
`timescale 1ns/10ps
`default_nettype none

module wb_pop_port (
     input  wire                      rclk
    ,input  wire                      rst_n

    ,input  wire                      pop_cyc
    ,input  wire                      pop_stb
    ,input  wire                      pop_we
    ,input  wire                      pop_adr
    ,input  wire fifo_pkg::byte_t     pop_dat_i
    ,output fifo_pkg::byte_t          pop_dat_o
    ,output logic                     pop_ack

    ,output fifo_pkg::ptr_t           rptr_gray
    ,input  wire fifo_pkg::ptr_t      wptr_bin

    ,output logic                     rf_re
    ,output fifo_pkg::rf_addr_t       rf_raddr
    ,input  wire fifo_pkg::byte_t     rf_rdata
);

    fifo_pkg::pop_state_e state;
    fifo_pkg::pop_state_e state_nxt;
    fifo_pkg::ptr_t       rptr_bin;
    fifo_pkg::ptr_t       rptr_bin_nxt;
    fifo_pkg::level_t     level;
    fifo_pkg::byte_t      status_q;
    logic                 empty;
    logic                 req;
    logic                 is_pop;
    logic                 ack_nxt;

    // --------------------------------------------------------------------------
    // Level and request decode
    // --------------------------------------------------------------------------

    // The write pointer lags behind, so the level may read low but never high
    assign level = wptr_bin - rptr_bin;
    assign empty = (level == '0);

    assign req    = pop_cyc & pop_stb & ~pop_ack;
    assign is_pop = ~pop_we & (fifo_pkg::wb_reg_e'(pop_adr) == fifo_pkg::reg_data);

    // Status reads and writes ack right away, write data on pop_dat_i is dropped
    // A fetched byte acks as the machine leaves fetch
    assign ack_nxt = (req & ~is_pop & (state == fifo_pkg::idle))
                   | (state == fifo_pkg::fetch);

    assign rf_re        = (state == fifo_pkg::fetch);
    assign rf_raddr     = rptr_bin[fifo_pkg::addr_width-1:0];
    assign rptr_bin_nxt = rptr_bin + 1'b1;

    // --------------------------------------------------------------------------
    // Pop machine
    // --------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            fifo_pkg::idle: begin
                // A pop on an empty FIFO waits here with ack low
                if (req & is_pop & ~empty) begin
                    state_nxt = fifo_pkg::fetch;
                end
            end
            fifo_pkg::fetch: state_nxt = fifo_pkg::ack;
            fifo_pkg::ack:   state_nxt = fifo_pkg::idle;
            default:         state_nxt = fifo_pkg::idle;
        endcase
    end

    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fifo_pkg::idle;
            pop_ack   <= 1'b0;
            rptr_bin  <= '0;
            rptr_gray <= '0;
        end else begin
            state   <= state_nxt;
            pop_ack <= ack_nxt;
            // The row is released on the edge that delivers its byte
            if (state == fifo_pkg::fetch) begin
                rptr_bin  <= rptr_bin_nxt;
                rptr_gray <= rptr_bin_nxt ^ (rptr_bin_nxt >> 1);
            end
        end
    end

    // Status byte captured when the request is seen
    always_ff @(posedge rclk) begin
        if (req) begin
            status_q <= {empty, level};
        end
    end

    // Register file data while acking a pop, status byte otherwise
    assign pop_dat_o = (state == fifo_pkg::ack) ? rf_rdata : status_q;

endmodule

`default_nettype wire

/* byte_fifo_top.sv */
// Byte FIFO top level
// Two-clock FIFO of 64 bytes with a Wishbone push port on wclk and a
// Wishbone pop port on rclk, pointers cross the domains as Gray codes
`timescale 1ns/10ps
`default_nettype none

module byte_fifo_top (
     input  wire                      wclk
    ,input  wire                      rclk
    ,input  wire                      arst_n

    ,input  wire                      push_cyc
    ,input  wire                      push_stb
    ,input  wire                      push_we
    ,input  wire                      push_adr
    ,input  wire fifo_pkg::byte_t     push_dat_i
    ,output wire fifo_pkg::byte_t     push_dat_o
    ,output wire                      push_ack

    ,input  wire                      pop_cyc
    ,input  wire                      pop_stb
    ,input  wire                      pop_we
    ,input  wire                      pop_adr
    ,input  wire fifo_pkg::byte_t     pop_dat_i
    ,output wire fifo_pkg::byte_t     pop_dat_o
    ,output wire                      pop_ack
);

    wire                     wclk_rst_n;
    wire                     rclk_rst_n;
    wire fifo_pkg::ptr_t     wptr_gray;
    wire fifo_pkg::ptr_t     rptr_gray;
    wire fifo_pkg::ptr_t     wptr_bin_rclk;
    wire fifo_pkg::ptr_t     rptr_bin_wclk;
    wire                     rf_we;
    wire fifo_pkg::rf_addr_t rf_waddr;
    wire fifo_pkg::byte_t    rf_wdata;
    wire                     rf_re;
    wire fifo_pkg::rf_addr_t rf_raddr;
    wire fifo_pkg::byte_t    rf_rdata;

    // --------------------------------------------------------------------------
    // Per-domain reset release
    // --------------------------------------------------------------------------

    reset_sync i_wclk_rst_sync (
         .clk     (wclk)
        ,.arst_n  (arst_n)
        ,.rst_n   (wclk_rst_n)
    );

    reset_sync i_rclk_rst_sync (
         .clk     (rclk)
        ,.arst_n  (arst_n)
        ,.rst_n   (rclk_rst_n)
    );

    // --------------------------------------------------------------------------
    // Push side, storage and pointer crossings, pop side
    // --------------------------------------------------------------------------

    wb_push_port i_push_port (
         .wclk        (wclk)
        ,.rst_n       (wclk_rst_n)
        ,.push_cyc    (push_cyc)
        ,.push_stb    (push_stb)
        ,.push_we     (push_we)
        ,.push_adr    (push_adr)
        ,.push_dat_i  (push_dat_i)
        ,.push_dat_o  (push_dat_o)
        ,.push_ack    (push_ack)
        ,.wptr_gray   (wptr_gray)
        ,.rptr_bin    (rptr_bin_wclk)
        ,.rf_we       (rf_we)
        ,.rf_waddr    (rf_waddr)
        ,.rf_wdata    (rf_wdata)
    );

    rf_2p_64x8 i_rf (
         .wclk   (wclk)
        ,.we     (rf_we)
        ,.waddr  (rf_waddr)
        ,.wdata  (rf_wdata)
        ,.rclk   (rclk)
        ,.re     (rf_re)
        ,.raddr  (rf_raddr)
        ,.rdata  (rf_rdata)
    );

    // Write pointer into the read domain
    gray_ptr_sync i_wptr_sync (
         .clk      (rclk)
        ,.rst_n    (rclk_rst_n)
        ,.gray_in  (wptr_gray)
        ,.bin_out  (wptr_bin_rclk)
    );

    // Read pointer into the write domain
    gray_ptr_sync i_rptr_sync (
         .clk      (wclk)
        ,.rst_n    (wclk_rst_n)
        ,.gray_in  (rptr_gray)
        ,.bin_out  (rptr_bin_wclk)
    );

    wb_pop_port i_pop_port (
         .rclk       (rclk)
        ,.rst_n      (rclk_rst_n)
        ,.pop_cyc    (pop_cyc)
        ,.pop_stb    (pop_stb)
        ,.pop_we     (pop_we)
        ,.pop_adr    (pop_adr)
        ,.pop_dat_i  (pop_dat_i)
        ,.pop_dat_o  (pop_dat_o)
        ,.pop_ack    (pop_ack)
        ,.rptr_gray  (rptr_gray)
        ,.wptr_bin   (wptr_bin_rclk)
        ,.rf_re      (rf_re)
        ,.rf_raddr   (rf_raddr)
        ,.rf_rdata   (rf_rdata)
    );

endmodule

`default_nettype wire

/* tb_byte_fifo.sv */
// Byte FIFO testbench
// Directed tests of the two-clock FIFO through its Wishbone push and pop
// ports, with a queue as reference model and a watchdog on the run time
`timescale 1ns/10ps
`default_nettype none

module tb_byte_fifo;

    localparam int clk_period_ns  = 100;
    localparam int rclk_offset_ns = 30;
    localparam int reset_cycles   = 16;
    // Watchdog budget in transactions, each allowed up to ten clock cycles
    localparam int watchdog_txns  = 600;
    localparam int cycles_per_txn = 10;
    localparam int stall_cycles   = 20;
    localparam int stream_len     = 300;

    logic            wclk;
    logic            rclk;
    logic            rclk_started = 1'b0;
    logic            arst_n;
    logic            push_cyc;
    logic            push_stb;
    logic            push_we;
    logic            push_adr;
    fifo_pkg::byte_t push_dat_i;
    wire  [7:0]      push_dat_o;
    wire             push_ack;
    logic            pop_cyc;
    logic            pop_stb;
    logic            pop_we;
    logic            pop_adr;
    fifo_pkg::byte_t pop_dat_i;
    wire  [7:0]      pop_dat_o;
    wire             pop_ack;

    // Bytes accepted by the push port, oldest at the front
    fifo_pkg::byte_t model_q [$];

    byte_fifo_top dut0 (
         .wclk        (wclk)
        ,.rclk        (rclk)
        ,.arst_n      (arst_n)
        ,.push_cyc    (push_cyc)
        ,.push_stb    (push_stb)
        ,.push_we     (push_we)
        ,.push_adr    (push_adr)
        ,.push_dat_i  (push_dat_i)
        ,.push_dat_o  (push_dat_o)
        ,.push_ack    (push_ack)
        ,.pop_cyc     (pop_cyc)
        ,.pop_stb     (pop_stb)
        ,.pop_we      (pop_we)
        ,.pop_adr     (pop_adr)
        ,.pop_dat_i   (pop_dat_i)
        ,.pop_dat_o   (pop_dat_o)
        ,.pop_ack     (pop_ack)
    );

    // ------------------------------------------------------------------------
    // Clocks and watchdog
    // ------------------------------------------------------------------------

    always begin
        #(clk_period_ns / 2) wclk = ~wclk;
    end

    // The read clock starts late so its edges never line up with wclk
    always begin
        if (!rclk_started) begin
            #(rclk_offset_ns);
            rclk_started = 1'b1;
        end
        #(clk_period_ns / 2) rclk = ~rclk;
    end

    initial begin
        #(watchdog_txns * cycles_per_txn * clk_period_ns);
        abort_run("Watchdog expired, a Wishbone cycle never received its ack");
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Status byte as the ports return it, flag in bit 7 and the seven
    // level bits below it
    function automatic fifo_pkg::byte_t status_value(input logic flag, input int level);
        status_value = {flag, 7'(level)};
    endfunction

    // One Wishbone classic cycle on the push port, waits for ack
    task automatic push_cycle(input logic we, input logic adr, input fifo_pkg::byte_t wdata,
                              output fifo_pkg::byte_t rdata);
        @(negedge wclk);
        push_cyc   = 1'b1;
        push_stb   = 1'b1;
        push_we    = we;
        push_adr   = adr;
        push_dat_i = wdata;
        @(negedge wclk);
        while (!push_ack) @(negedge wclk);
        rdata    = push_dat_o;
        push_cyc = 1'b0;
        push_stb = 1'b0;
        push_we  = 1'b0;
    endtask

    // Same cycle on the pop port
    task automatic pop_cycle(input logic we, input logic adr, input fifo_pkg::byte_t wdata,
                             output fifo_pkg::byte_t rdata);
        @(negedge rclk);
        pop_cyc   = 1'b1;
        pop_stb   = 1'b1;
        pop_we    = we;
        pop_adr   = adr;
        pop_dat_i = wdata;
        @(negedge rclk);
        while (!pop_ack) @(negedge rclk);
        rdata   = pop_dat_o;
        pop_cyc = 1'b0;
        pop_stb = 1'b0;
        pop_we  = 1'b0;
    endtask

    task automatic push_byte(input fifo_pkg::byte_t data);
        fifo_pkg::byte_t rd;
        push_cycle(1'b1, fifo_pkg::reg_data, data, rd);
        model_q.push_back(data);
    endtask

    task automatic push_status(output fifo_pkg::byte_t st);
        push_cycle(1'b0, fifo_pkg::reg_status, 8'h00, st);
    endtask

    task automatic pop_status(output fifo_pkg::byte_t st);
        pop_cycle(1'b0, fifo_pkg::reg_status, 8'h00, st);
    endtask

    // Pops one byte and compares it with the oldest byte of the model
    task automatic pop_byte();
        fifo_pkg::byte_t rd;
        pop_cycle(1'b0, fifo_pkg::reg_data, 8'h00, rd);
        if (model_q.size() == 0) begin
            abort_run("Pop port returned a byte while the model holds none");
        end else begin
            check_equal("pop_dat_o", rd, model_q.pop_front());
        end
    endtask

    // Polls the pop status until the read side sees the given level
    task automatic wait_pop_level(input int level);
        fifo_pkg::byte_t st;
        pop_status(st);
        while (st !== status_value(level == 0, level)) pop_status(st);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        fifo_pkg::byte_t st;
        push_status(st);
        check_equal("push status", st, status_value(1'b0, 0));
        pop_status(st);
        check_equal("pop status", st, status_value(1'b1, 0));
    endtask

    task automatic test_order();
        fifo_pkg::byte_t st;
        repeat (20) push_byte(fifo_pkg::byte_t'($urandom));
        repeat (20) pop_byte();
        pop_status(st);
        check_equal("pop status", st, status_value(1'b1, 0));
    endtask

    task automatic test_full();
        fifo_pkg::byte_t st;
        repeat (fifo_pkg::fifo_depth) push_byte(fifo_pkg::byte_t'($urandom));
        push_status(st);
        check_equal("push status", st, status_value(1'b1, fifo_pkg::fifo_depth));
        // The extra push must stall until the pop frees a row
        fork
            push_byte(fifo_pkg::byte_t'($urandom));
            begin
                repeat (stall_cycles) begin
                    @(negedge wclk);
                    check_equal("push_ack", push_ack, 1'b0);
                end
                pop_byte();
            end
        join
        repeat (fifo_pkg::fifo_depth) pop_byte();
    endtask

    task automatic test_empty_stall();
        fork
            pop_byte();
            begin
                repeat (stall_cycles) begin
                    @(negedge rclk);
                    check_equal("pop_ack", pop_ack, 1'b0);
                end
                push_byte(fifo_pkg::byte_t'($urandom));
            end
        join
    endtask

    task automatic test_stream();
        fork
            repeat (stream_len) begin
                repeat ($urandom_range(0, 3)) @(negedge wclk);
                push_byte(fifo_pkg::byte_t'($urandom));
            end
            repeat (stream_len) begin
                repeat ($urandom_range(0, 3)) @(negedge rclk);
                pop_byte();
            end
        join
    endtask

    task automatic test_ignored_access();
        fifo_pkg::byte_t rd;
        fifo_pkg::byte_t st;
        repeat (5) push_byte(fifo_pkg::byte_t'($urandom));
        wait_pop_level(5);
        // A write to the pop data register is acked and dropped
        pop_cycle(1'b1, fifo_pkg::reg_data, fifo_pkg::byte_t'($urandom), rd);
        pop_status(st);
        check_equal("pop status", st, status_value(1'b0, 5));
        // Status first leaves a nonzero byte on push_dat_o
        push_status(st);
        check_equal("push status", st, status_value(1'b0, 5));
        push_cycle(1'b0, fifo_pkg::reg_data, 8'h00, rd);
        check_equal("push_dat_o", rd, 8'h00);
        repeat (5) pop_byte();
        pop_status(st);
        check_equal("pop status", st, status_value(1'b1, 0));
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(61));
        wclk         = 1'b0;
        rclk         = 1'b0;
        arst_n       = 1'b0;
        push_cyc     = 1'b0;
        push_stb     = 1'b0;
        push_we      = 1'b0;
        push_adr     = 1'b0;
        push_dat_i   = '0;
        pop_cyc      = 1'b0;
        pop_stb      = 1'b0;
        pop_we       = 1'b0;
        pop_adr      = 1'b0;
        pop_dat_i    = '0;
        repeat (reset_cycles) @(posedge wclk);
        @(negedge wclk);
        arst_n = 1'b1;
        // Leave time for both reset synchronizers to release
        repeat (4) @(negedge wclk);

        test_reset_state();
        test_order();
        test_full();
        test_empty_stall();
        test_stream();
        test_ignored_access();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* byte_fifo_top.f */
fifo_pkg.sv
reset_sync.sv
gray_ptr_sync.sv
rf_2p_64x8.sv
wb_push_port.sv
wb_pop_port.sv
byte_fifo_top.sv
tb_byte_fifo.sv

/* Bender.yml */
package:
  name: byte_fifo

sources:
  - files:
      - fifo_pkg.sv
      - reset_sync.sv
      - gray_ptr_sync.sv
      - rf_2p_64x8.sv
      - wb_push_port.sv
      - wb_pop_port.sv
      - byte_fifo_top.sv
  - target: test
    files:
      - tb_byte_fifo.sv
